/* include/rx_frame_defs.svh */
`ifndef RX_FRAME_DEFS_SVH
`define RX_FRAME_DEFS_SVH

// legacy SIGNAL field length in bytes
`define RX_SIGNAL_BYTES 3

// reflected form of the 802.3 CRC-32 generator
`define RX_CRC_POLY 32'hEDB88320

// register preset before the first payload byte
`define RX_CRC_INIT 32'hFFFFFFFF

// magic remainder left after payload plus a correct FCS
// (msb-first view of the register)
`define RX_FCS_RESIDUE 32'hC704DD7B

`endif

/* src/rx_frame_pkg.sv */
package rx_frame_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0] byte_t;

    // byte 0 of the SIGNAL field sits in bits 7..0
    typedef logic [23:0] signal_word_t;

    typedef logic [3:0] rate_t;

    // payload length incl. FCS, also used for byte counts
    typedef logic [11:0] pkt_len_t;

    typedef logic [31:0] crc_t;

    ////////////////////////////////////////////////////////////////////////////
    // frame status
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        STATUS_OK               = 3'd0,
        STATUS_PARITY_FAIL      = 3'd1,
        STATUS_WRONG_RSVD       = 3'd2,
        STATUS_WRONG_TAIL       = 3'd3,
        STATUS_UNSUPPORTED_RATE = 3'd4,
        STATUS_WRONG_FCS        = 3'd5
    } status_code_e;

    ////////////////////////////////////////////////////////////////////////////
    // state machines
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACKED,
        HS_WAIT_RELEASE
    } hs_state_e;

    typedef enum logic {
        PS_SIGNAL,
        PS_PAYLOAD
    } parser_state_e;

    typedef enum logic {
        PL_IDLE,
        PL_PAYLOAD
    } payload_state_e;

endpackage

/* src/byte_handshake_rx.sv */
`timescale 1ns/1ps

module byte_handshake_rx import rx_frame_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  byte_req_i,
    input  byte_t byte_i,
    output logic  byte_ack_o,
    output logic  rx_valid_o,
    output byte_t rx_byte_o
);

    hs_state_e state;
    logic      capture;

    // a new request is only honoured from idle
    assign capture = (state == HS_IDLE) && byte_req_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= HS_IDLE;
            byte_ack_o <= 1'b0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= capture;
            case (state)
                HS_IDLE: begin
                    if (byte_req_i) begin
                        byte_ack_o <= 1'b1;
                        state      <= HS_ACKED;
                    end
                end
                // first ack cycle, rx_valid is high here
                HS_ACKED: begin
                    if (!byte_req_i) begin
                        byte_ack_o <= 1'b0;
                        state      <= HS_IDLE;
                    end else begin
                        state <= HS_WAIT_RELEASE;
                    end
                end
                // hold ack until the source lets go of req
                HS_WAIT_RELEASE: begin
                    if (!byte_req_i) begin
                        byte_ack_o <= 1'b0;
                        state      <= HS_IDLE;
                    end
                end
                default: begin
                    byte_ack_o <= 1'b0;
                    state      <= HS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            rx_byte_o <= byte_i;
        end
    end

endmodule

/* src/signal_field_parser.sv */
`timescale 1ns/1ps

`include "rx_frame_defs.svh"

module signal_field_parser import rx_frame_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         rx_valid_i,
    input  byte_t        rx_byte_i,
    output logic         header_strobe_o,
    output logic         header_ok_o,
    output status_code_e header_status_o,
    output rate_t        pkt_rate_o,
    output pkt_len_t     pkt_len_o,
    output logic         pay_valid_o,
    output byte_t        pay_byte_o,
    output logic         busy_o
);

    localparam logic [1:0] SIG_LAST = 2'(`RX_SIGNAL_BYTES - 1);

    parser_state_e state;
    signal_word_t  sig_word;
    signal_word_t  sig_next;
    logic [1:0]    sig_count;
    pkt_len_t      pay_count;
    // delays the busy release until the checker has its FCS verdict
    logic [1:0]    end_pipe;
    status_code_e  sig_status;

    rate_t         sig_rate;
    logic          sig_rsvd;
    pkt_len_t      sig_len;
    logic          sig_parity_ok;
    logic [5:0]    sig_tail;

    // new byte enters at the top, byte 0 ends up in bits 7..0
    assign sig_next = {rx_byte_i, sig_word[23:8]};

    assign sig_rate      = sig_next[3:0];
    assign sig_rsvd      = sig_next[4];
    assign sig_len       = sig_next[16:5];
    assign sig_parity_ok = ~^sig_next[17:0];
    assign sig_tail      = sig_next[23:18];

    // checks in priority order
    always_comb begin
        if (!sig_parity_ok) begin
            sig_status = STATUS_PARITY_FAIL;
        end else if (sig_rsvd) begin
            sig_status = STATUS_WRONG_RSVD;
        end else if (|sig_tail) begin
            sig_status = STATUS_WRONG_TAIL;
        end else if (!sig_rate[3]) begin
            sig_status = STATUS_UNSUPPORTED_RATE;
        end else begin
            sig_status = STATUS_OK;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state           <= PS_SIGNAL;
            sig_count       <= '0;
            pay_count       <= '0;
            end_pipe        <= '0;
            header_strobe_o <= 1'b0;
            header_ok_o     <= 1'b0;
            header_status_o <= STATUS_OK;
            pay_valid_o     <= 1'b0;
            busy_o          <= 1'b0;
        end else begin
            header_strobe_o <= 1'b0;
            pay_valid_o     <= 1'b0;
            end_pipe        <= {end_pipe[0], 1'b0};
            if (end_pipe[1]) begin
                busy_o <= 1'b0;
            end

            case (state)
                PS_SIGNAL: begin
                    if (rx_valid_i) begin
                        // may overlap the release of the previous frame
                        busy_o <= 1'b1;
                        if (sig_count == SIG_LAST) begin
                            sig_count       <= '0;
                            header_strobe_o <= 1'b1;
                            header_ok_o     <= (sig_status == STATUS_OK);
                            header_status_o <= sig_status;
                            if (sig_status != STATUS_OK || sig_len == '0) begin
                                busy_o <= 1'b0;
                            end else begin
                                pay_count <= '0;
                                state     <= PS_PAYLOAD;
                            end
                        end else begin
                            sig_count <= sig_count + 2'd1;
                        end
                    end
                end
                PS_PAYLOAD: begin
                    if (rx_valid_i) begin
                        pay_valid_o <= 1'b1;
                        pay_count   <= pay_count + 12'd1;
                        if (pay_count + 12'd1 == pkt_len_o) begin
                            end_pipe <= {end_pipe[0], 1'b1};
                            state    <= PS_SIGNAL;
                        end
                    end
                end
                default: begin
                    state <= PS_SIGNAL;
                end
            endcase
        end
    end

    // payload side, no reset needed
    always_ff @(posedge clock) begin
        if (rx_valid_i && state == PS_SIGNAL) begin
            sig_word <= sig_next;
            if (sig_count == SIG_LAST) begin
                pkt_rate_o <= sig_rate;
                pkt_len_o  <= sig_len;
            end
        end
        if (rx_valid_i && state == PS_PAYLOAD) begin
            pay_byte_o <= rx_byte_i;
        end
    end

endmodule

/* src/crc32_byte.sv */
`timescale 1ns/1ps

`include "rx_frame_defs.svh"

module crc32_byte import rx_frame_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  clear_i,
    input  logic  enable_i,
    input  byte_t data_i,
    output crc_t  crc_o
);

    // one byte, lsb first, right-shifting register
    function automatic crc_t crc_fold(crc_t crc_in, byte_t data);
        crc_t c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ `RX_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            crc_o <= `RX_CRC_INIT;
        end else if (enable_i) begin
            crc_o <= crc_fold(crc_o, data_i);
        end
    end

endmodule

/* src/payload_fcs_checker.sv */
`timescale 1ns/1ps

`include "rx_frame_defs.svh"

module payload_fcs_checker import rx_frame_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         header_strobe_i,
    input  logic         header_ok_i,
    input  status_code_e header_status_i,
    input  pkt_len_t     pkt_len_i,
    input  logic         pay_valid_i,
    input  byte_t        pay_byte_i,
    output logic         byte_out_strobe_o,
    output byte_t        byte_out_o,
    output pkt_len_t     byte_count_o,
    output logic         fcs_strobe_o,
    output logic         fcs_ok_o,
    output status_code_e status_code_o
);

    payload_state_e state;
    status_code_e   status_q;
    logic           crc_clear;
    logic           crc_enable;
    crc_t           crc_value;
    crc_t           crc_msb_first;
    logic           last_byte;
    logic           fcs_match;

    assign crc_clear  = header_strobe_i && header_ok_i;
    assign crc_enable = pay_valid_i && (state == PL_PAYLOAD);

    crc32_byte crc_i (
        .clock    (clock),
        .reset    (reset),
        .clear_i  (crc_clear),
        .enable_i (crc_enable),
        .data_i   (pay_byte_i),
        .crc_o    (crc_value)
    );

    // residue is given msb first, the register runs reflected
    assign crc_msb_first = {<<{crc_value}};
    assign fcs_match     = (crc_msb_first == `RX_FCS_RESIDUE);

    // register already holds the last byte when its strobe is out
    assign last_byte = (state == PL_PAYLOAD) && byte_out_strobe_o
                       && (byte_count_o == pkt_len_i);

    // header status shows up in the same cycle as the header strobe
    assign status_code_o = header_strobe_i ? header_status_i : status_q;

    ////////////////////////////////////////////////////////////////////////////
    // count, verdict and status
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state             <= PL_IDLE;
            byte_out_strobe_o <= 1'b0;
            byte_count_o      <= '0;
            fcs_strobe_o      <= 1'b0;
            fcs_ok_o          <= 1'b0;
            status_q          <= STATUS_OK;
        end else begin
            byte_out_strobe_o <= 1'b0;
            fcs_strobe_o      <= 1'b0;

            if (header_strobe_i) begin
                status_q     <= header_status_i;
                byte_count_o <= '0;
                state        <= header_ok_i ? PL_PAYLOAD : PL_IDLE;
            end else if (state == PL_PAYLOAD) begin
                if (pay_valid_i) begin
                    byte_out_strobe_o <= 1'b1;
                    byte_count_o      <= byte_count_o + 12'd1;
                end
                if (last_byte) begin
                    fcs_strobe_o <= 1'b1;
                    fcs_ok_o     <= fcs_match;
                    status_q     <= fcs_match ? STATUS_OK : STATUS_WRONG_FCS;
                    state        <= PL_IDLE;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pay_valid_i) begin
            byte_out_o <= pay_byte_i;
        end
    end

endmodule

/* src/rx_frame_top.sv */
`timescale 1ns/1ps

module rx_frame_top import rx_frame_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         byte_req_i,
    input  byte_t        byte_i,
    output logic         byte_ack_o,
    output logic         demod_busy_o,
    output logic         header_strobe_o,
    output logic         header_ok_o,
    output rate_t        pkt_rate_o,
    output pkt_len_t     pkt_len_o,
    output logic         byte_out_strobe_o,
    output byte_t        byte_out_o,
    output pkt_len_t     byte_count_o,
    output logic         fcs_strobe_o,
    output logic         fcs_ok_o,
    output status_code_e status_code_o
);

    logic         rx_valid;
    byte_t        rx_byte;
    logic         pay_valid;
    byte_t        pay_byte;
    status_code_e header_status;

    ////////////////////////////////////////////////////////////////////////////
    // handshake -> SIGNAL parser -> payload and FCS
    ////////////////////////////////////////////////////////////////////////////

    byte_handshake_rx handshake_i (
        .clock      (clock),
        .reset      (reset),
        .byte_req_i (byte_req_i),
        .byte_i     (byte_i),
        .byte_ack_o (byte_ack_o),
        .rx_valid_o (rx_valid),
        .rx_byte_o  (rx_byte)
    );

    signal_field_parser parser_i (
        .clock           (clock),
        .reset           (reset),
        .rx_valid_i      (rx_valid),
        .rx_byte_i       (rx_byte),
        .header_strobe_o (header_strobe_o),
        .header_ok_o     (header_ok_o),
        .header_status_o (header_status),
        .pkt_rate_o      (pkt_rate_o),
        .pkt_len_o       (pkt_len_o),
        .pay_valid_o     (pay_valid),
        .pay_byte_o      (pay_byte),
        .busy_o          (demod_busy_o)
    );

    payload_fcs_checker checker_i (
        .clock             (clock),
        .reset             (reset),
        .header_strobe_i   (header_strobe_o),
        .header_ok_i       (header_ok_o),
        .header_status_i   (header_status),
        .pkt_len_i         (pkt_len_o),
        .pay_valid_i       (pay_valid),
        .pay_byte_i        (pay_byte),
        .byte_out_strobe_o (byte_out_strobe_o),
        .byte_out_o        (byte_out_o),
        .byte_count_o      (byte_count_o),
        .fcs_strobe_o      (fcs_strobe_o),
        .fcs_ok_o          (fcs_ok_o),
        .status_code_o     (status_code_o)
    );

endmodule

/* tb/rx_frame_assert.sv */
`timescale 1ns/1ps

module rx_frame_assert (
    input logic clock,
    input logic reset,
    input logic req_i,
    input logic ack_i,
    input logic busy_i,
    input logic header_strobe_i,
    input logic byte_out_strobe_i,
    input logic fcs_strobe_i
);

    // ack may only answer a request
    ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(ack_i) |-> $past(req_i))
        else $error("byte_ack_o rose while byte_req_i was low");

    // no early release of ack
    ack_held: assert property (@(posedge clock) disable iff (reset)
        (ack_i && req_i) |=> ack_i)
        else $error("byte_ack_o fell before byte_req_i was released");

    header_pulse: assert property (@(posedge clock) disable iff (reset)
        header_strobe_i |=> !header_strobe_i)
        else $error("header_strobe_o lasted more than one cycle");

    fcs_pulse: assert property (@(posedge clock) disable iff (reset)
        fcs_strobe_i |=> !fcs_strobe_i)
        else $error("fcs_strobe_o lasted more than one cycle");

    out_needs_busy: assert property (@(posedge clock) disable iff (reset)
        byte_out_strobe_i |-> busy_i)
        else $error("byte_out_strobe_o while demod_busy_o was low");

endmodule

/* tb/tb_rx_frame.sv */
`timescale 1ns/1ps

module tb_rx_frame import rx_frame_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int MEM_WORDS    = 512;
    localparam int MAX_FRAMES   = 32;
    // worst case per byte: two 3-cycle gaps, two ack edges, some slack
    localparam int BYTE_CYCLES  = 12;
    localparam int SLACK_CYCLES = 200;

    logic         clock;
    logic         reset;
    logic         byte_req;
    byte_t        byte_data;
    logic         byte_ack;
    logic         busy;
    logic         header_strobe;
    logic         header_ok;
    rate_t        pkt_rate;
    pkt_len_t     pkt_len;
    logic         byte_out_strobe;
    byte_t        byte_out;
    pkt_len_t     byte_count;
    logic         fcs_strobe;
    logic         fcs_ok;
    status_code_e status_code;

    byte_t        pattern_mem  [0:MEM_WORDS-1];
    int           frame_first  [0:MAX_FRAMES-1];
    int           frame_bytes  [0:MAX_FRAMES-1];
    // bytes sent up to and including this frame
    int           frame_acc    [0:MAX_FRAMES-1];
    logic         frame_hdr_ok [0:MAX_FRAMES-1];
    status_code_e frame_status [0:MAX_FRAMES-1];
    logic         frame_fcs_ok [0:MAX_FRAMES-1];
    int           num_frames;
    int           total_bytes;
    int           expected_payload;
    bit           patterns_ready;
    logic [15:0]  lfsr;

    int           mon_frame;
    int           mon_count;
    int           strobe_total;
    int           acks_seen;
    logic         ack_prev;
    bit           in_payload;
    bit           monitor_on;

    rx_frame_top dut_i (
        .clock             (clock),
        .reset             (reset),
        .byte_req_i        (byte_req),
        .byte_i            (byte_data),
        .byte_ack_o        (byte_ack),
        .demod_busy_o      (busy),
        .header_strobe_o   (header_strobe),
        .header_ok_o       (header_ok),
        .pkt_rate_o        (pkt_rate),
        .pkt_len_o         (pkt_len),
        .byte_out_strobe_o (byte_out_strobe),
        .byte_out_o        (byte_out),
        .byte_count_o      (byte_count),
        .fcs_strobe_o      (fcs_strobe),
        .fcs_ok_o          (fcs_ok),
        .status_code_o     (status_code)
    );

    bind rx_frame_top rx_frame_assert assert_i (
        .clock             (clock),
        .reset             (reset),
        .req_i             (byte_req_i),
        .ack_i             (byte_ack_o),
        .busy_i            (demod_busy_o),
        .header_strobe_i   (header_strobe_o),
        .byte_out_strobe_i (byte_out_strobe_o),
        .fcs_strobe_i      (fcs_strobe_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_on_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // 16-bit Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic random_gap();
        logic [1:0] gap;
        gap = 2'b00;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            gap  = {gap[0], lfsr[0]};
        end
        repeat (gap) @(negedge clock);
    endtask

    // SIGNAL layout: rate 3..0, reserved 4, length 16..5, parity 17, tail 23..18
    function automatic rate_t field_rate(input byte_t b0);
        return b0[3:0];
    endfunction

    function automatic pkt_len_t field_length(input byte_t b0, input byte_t b1,
                                              input byte_t b2);
        signal_word_t word;
        word = {b2, b1, b0};
        return word[16:5];
    endfunction

    task automatic load_patterns();
        int idx;
        idx = 0;
        num_frames = 0;
        total_bytes = 0;
        expected_payload = 0;
        $readmemh("tb/rx_frame_patterns.txt", pattern_mem);
        while (idx < MEM_WORDS && pattern_mem[idx] != 8'h00 && num_frames < MAX_FRAMES) begin
            frame_bytes[num_frames]  = int'(pattern_mem[idx]);
            frame_hdr_ok[num_frames] = pattern_mem[idx + 1][0];
            frame_status[num_frames] = status_code_e'(pattern_mem[idx + 2][2:0]);
            frame_fcs_ok[num_frames] = pattern_mem[idx + 3][0];
            frame_first[num_frames]  = idx + 4;
            total_bytes = total_bytes + frame_bytes[num_frames];
            frame_acc[num_frames] = total_bytes;
            if (frame_hdr_ok[num_frames]) begin
                expected_payload = expected_payload + frame_bytes[num_frames] - 3;
            end
            idx = idx + 4 + frame_bytes[num_frames];
            num_frames = num_frames + 1;
        end
        if (num_frames == 0) begin
            stop_on_failure("The pattern file holds no frames");
        end
        patterns_ready = 1'b1;
    endtask

    // four-phase source side
    task automatic send_byte(input byte_t data);
        random_gap();
        byte_data = data;
        byte_req  = 1'b1;
        @(negedge clock);
        while (!byte_ack) @(negedge clock);
        random_gap();
        byte_req = 1'b0;
        @(negedge clock);
        while (byte_ack) @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // clock, stimulus and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin : stimulus
        reset     = 1'b1;
        byte_req  = 1'b0;
        byte_data = 8'h00;
        lfsr      = 16'd40;
        load_patterns();
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (!byte_ack && !header_strobe && !header_ok && !byte_out_strobe
                && !fcs_strobe && !fcs_ok && !busy)
            else stop_on_failure("A control output is active after reset");
        assert (status_code == STATUS_OK)
            else report_mismatch("status_code_o", 32'(status_code), 32'(STATUS_OK));
        mon_frame    = 0;
        mon_count    = 0;
        strobe_total = 0;
        acks_seen    = 0;
        ack_prev     = 1'b0;
        monitor_on   = 1'b1;
        for (int f = 0; f < num_frames; f++) begin
            for (int k = 0; k < frame_bytes[f]; k++) begin
                send_byte(pattern_mem[frame_first[f] + k]);
            end
        end
        // wait for the last verdict
        while (mon_frame < num_frames) @(negedge clock);
        assert (strobe_total == expected_payload)
            else report_mismatch("byte_out_strobe_o count", 32'(strobe_total),
                                 32'(expected_payload));
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        wait (patterns_ready);
        #((total_bytes * BYTE_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
        stop_on_failure("Timeout: the frames did not finish in the expected time");
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin : monitor
        int       base;
        byte_t    exp_byte;
        pkt_len_t exp_len;
        if (monitor_on) begin
            if (header_strobe) begin
                if (mon_frame >= num_frames || in_payload) begin
                    stop_on_failure("A header strobe came where no header was expected");
                end
                base = frame_first[mon_frame];
                assert (header_ok == frame_hdr_ok[mon_frame])
                    else report_mismatch("header_ok_o", 32'(header_ok),
                                         32'(frame_hdr_ok[mon_frame]));
                if (header_ok) begin
                    exp_len = field_length(pattern_mem[base], pattern_mem[base + 1],
                                           pattern_mem[base + 2]);
                    assert (pkt_rate == field_rate(pattern_mem[base]))
                        else report_mismatch("pkt_rate_o", 32'(pkt_rate),
                                             32'(field_rate(pattern_mem[base])));
                    assert (pkt_len == exp_len)
                        else report_mismatch("pkt_len_o", 32'(pkt_len), 32'(exp_len));
                    assert (status_code == STATUS_OK)
                        else report_mismatch("status_code_o", 32'(status_code),
                                             32'(STATUS_OK));
                    in_payload = 1'b1;
                    mon_count  = 0;
                end else begin
                    assert (!busy)
                        else stop_on_failure("demod_busy_o stayed high after a header error");
                    assert (status_code == frame_status[mon_frame])
                        else report_mismatch("status_code_o", 32'(status_code),
                                             32'(frame_status[mon_frame]));
                    mon_frame = mon_frame + 1;
                end
            end
            if (byte_out_strobe) begin
                if (!in_payload) begin
                    stop_on_failure("A payload byte came out of a frame without a good header");
                end
                exp_byte = pattern_mem[frame_first[mon_frame] + 3 + mon_count];
                assert (byte_out == exp_byte)
                    else report_mismatch("byte_out_o", 32'(byte_out), 32'(exp_byte));
                assert (byte_count == pkt_len_t'(mon_count + 1))
                    else report_mismatch("byte_count_o", 32'(byte_count), 32'(mon_count + 1));
                mon_count    = mon_count + 1;
                strobe_total = strobe_total + 1;
            end
            if (fcs_strobe) begin
                if (!in_payload || mon_count != frame_bytes[mon_frame] - 3) begin
                    stop_on_failure("The FCS verdict came before all payload bytes were out");
                end
                assert (fcs_ok == frame_fcs_ok[mon_frame])
                    else report_mismatch("fcs_ok_o", 32'(fcs_ok), 32'(frame_fcs_ok[mon_frame]));
                assert (status_code == frame_status[mon_frame])
                    else report_mismatch("status_code_o", 32'(status_code),
                                         32'(frame_status[mon_frame]));
                // busy may already be up again if the next frame has started
                if (acks_seen <= frame_acc[mon_frame]) begin
                    assert (!busy)
                        else stop_on_failure("demod_busy_o stayed high after the FCS verdict");
                end
                in_payload = 1'b0;
                mon_frame  = mon_frame + 1;
            end
            if (byte_ack && !ack_prev) begin
                acks_seen = acks_seen + 1;
            end
            ack_prev = byte_ack;
        end
    end

endmodule

/* tb/rx_frame_patterns.txt */
// per frame: byte count, header_ok, status, fcs_ok, then the bytes (SIGNAL first)
// all values hex; a count of 00 ends the list
10 1 0 1  AD 01 00 31 32 33 34 35 36 37 38 39 26 39 F4 CB
07 1 0 1  8B 00 00 00 00 00 00
03 0 1 0  AD 01 02
0A 1 0 1  EF 00 02 61 62 63 C2 41 24 35
03 0 2 0  BD 01 06
08 1 0 1  A9 00 00 61 43 BE B7 E8
03 0 3 0  A5 01 82
08 1 0 1  A8 00 02 00 8D EF 02 D2
03 0 4 0  A5 01 02
10 1 0 1  AD 01 00 31 32 33 34 35 36 37 38 39 26 39 F4 CB
// payload byte corrupted
0A 1 5 0  EF 00 02 61 62 62 C2 41 24 35
// FCS byte corrupted
10 1 5 0  AD 01 00 31 32 33 34 35 36 37 38 39 26 39 F4 CC
07 1 0 1  8B 00 00 00 00 00 00
00

/* compile.f */
+incdir+include
src/rx_frame_pkg.sv
src/byte_handshake_rx.sv
src/signal_field_parser.sv
src/crc32_byte.sv
src/payload_fcs_checker.sv
src/rx_frame_top.sv
tb/rx_frame_assert.sv
tb/tb_rx_frame.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rx_frame
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
